// File: include/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Word and line widths in bits
`define WORD_SIZE      32
`define LINE_SIZE      128

// Direct-mapped geometry
`define CACHE_SETS     8
`define OFFSET_SIZE    4
`define SET_SIZE       3
`define TAG_SIZE       25

// Store buffer slots
`define SB_ENTRIES     4

// Cycles from refill request to response
`define MEM_LATENCY    4
`define MEM_LINES      64

// Access size codes
`define BYTE_SIZE      2'b00
`define FULL_WORD_SIZE 2'b10

`endif

// File: hdl/mem_types_pkg.sv
`include "dcache_macros.svh"

package mem_types_pkg;

    // Data word, also used for byte addresses
    typedef logic [`WORD_SIZE-1:0] word_t;

    // One whole cache line
    typedef logic [`LINE_SIZE-1:0] line_t;

    // Address fields, from the top bit down
    typedef logic [`TAG_SIZE-1:0] tag_t;

    typedef logic [`SET_SIZE-1:0] set_t;

    // Byte position inside a line
    typedef logic [`OFFSET_SIZE-1:0] offset_t;

    // Pin count, one extra bit so that SB_ENTRIES itself fits
    typedef logic [$clog2(`SB_ENTRIES):0] pin_t;

    // BYTE_SIZE or FULL_WORD_SIZE
    typedef logic [1:0] acc_size_t;

endpackage

// File: hdl/cache_types_pkg.sv
`include "dcache_macros.svh"

package cache_types_pkg;

    import mem_types_pkg::*;

    // Request from the pipeline, held until accepted
    typedef struct packed {
        logic      valid;
        logic      store;
        acc_size_t size;
        word_t     addr;
        word_t     wdata;
    } cpu_req_t;

    // One store waiting to be written into the cache
    typedef struct packed {
        word_t     addr;
        acc_size_t size;
        word_t     value;
    } sb_entry_t;

    // Refill request, single-cycle pulse
    typedef struct packed {
        logic  strobe;
        word_t addr;
    } mem_req_t;

    // Refill response, single-cycle pulse
    typedef struct packed {
        logic  strobe;
        word_t addr;
        line_t data;
    } mem_res_t;

    // Victim write-back, single-cycle pulse
    typedef struct packed {
        logic  strobe;
        word_t addr;
        line_t data;
    } mem_wr_t;

endpackage

// File: hdl/dcache.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_types_pkg::cpu_req_t  req,
    input  cache_types_pkg::mem_res_t  mem_res,
    input  cache_types_pkg::sb_entry_t sb_head,
    input  logic                       sb_drain,
    output logic                       hit,
    output logic                       store_stall,
    output mem_types_pkg::word_t       read_data,
    output cache_types_pkg::mem_req_t  mem_req,
    output cache_types_pkg::mem_wr_t   mem_wr,
    output logic                       store_success
);
    import mem_types_pkg::*;

    // Resident line state per set
    tag_t  tags  [`CACHE_SETS];
    line_t data  [`CACHE_SETS];
    logic  dirty [`CACHE_SETS];
    pin_t  pins  [`CACHE_SETS];

    // Missing request table with at most one open refill per set
    logic  mrq_present [`CACHE_SETS];
    tag_t  mrq_tag     [`CACHE_SETS];
    pin_t  mrq_pin     [`CACHE_SETS];

    // Pipeline address fields
    tag_t    req_tag;
    set_t    req_set;
    offset_t req_offset;

    // Store buffer head fields
    tag_t    sb_tag;
    set_t    sb_set;
    offset_t sb_offset;

    // Refill response fields
    tag_t    res_tag;
    set_t    res_set;

    logic  tag_match;
    logic  pin_on_hit;
    logic  pin_on_mrq;
    logic  refill;
    line_t read_line;
    line_t write_mask;
    line_t write_bits;

    assign req_tag    = req.addr[`WORD_SIZE-1 -: `TAG_SIZE];
    assign req_set    = req.addr[`OFFSET_SIZE +: `SET_SIZE];
    assign req_offset = req.addr[`OFFSET_SIZE-1:0];

    assign sb_tag     = sb_head.addr[`WORD_SIZE-1 -: `TAG_SIZE];
    assign sb_set     = sb_head.addr[`OFFSET_SIZE +: `SET_SIZE];
    assign sb_offset  = sb_head.addr[`OFFSET_SIZE-1:0];

    assign res_tag    = mem_res.addr[`WORD_SIZE-1 -: `TAG_SIZE];
    assign res_set    = mem_res.addr[`OFFSET_SIZE +: `SET_SIZE];

    // Without valid bits tag zero matches the zeroed lines after reset
    assign tag_match = tags[req_set] == req_tag;
    assign hit       = req.valid && tag_match;

    // A resident line is pinned only if no refill is about to replace it
    assign pin_on_hit = req.valid && req.store && tag_match && !mrq_present[req_set];

    // Store to a line still on its way from memory
    assign pin_on_mrq = req.valid && req.store && !tag_match && mrq_present[req_set]
                        && mrq_tag[req_set] == req_tag;

    assign store_stall = req.valid && req.store && !(pin_on_hit || pin_on_mrq);

    // Selected bytes moved down to bit 0
    assign read_line = data[req_set] >> {req_offset, 3'b000};

    always_comb begin
        case (req.size)
            // Byte loads sign-extend
            `BYTE_SIZE:      read_data = {{(`WORD_SIZE-8){read_line[7]}}, read_line[7:0]};
            `FULL_WORD_SIZE: read_data = read_line[`WORD_SIZE-1:0];
            default:         read_data = '0;
        endcase
    end

    // Miss with nothing open for the set and no pinned victim
    assign mem_req.strobe = req.valid && !tag_match && pins[req_set] == '0
                            && !mrq_present[req_set];
    assign mem_req.addr   = {req_tag, req_set, {`OFFSET_SIZE{1'b0}}};

    assign refill = mem_res.strobe && mrq_present[res_set];

    // Dirty victim leaves in the response cycle
    assign mem_wr.strobe = refill && dirty[res_set];
    assign mem_wr.addr   = {tags[res_set], res_set, {`OFFSET_SIZE{1'b0}}};
    assign mem_wr.data   = data[res_set];

    // Drain waits while a refill owns the data arrays
    assign store_success = sb_drain && !mem_res.strobe && tags[sb_set] == sb_tag;

    // Byte lanes written by the head store
    assign write_mask = ((sb_head.size == `BYTE_SIZE) ? line_t'(8'hff)
                        : line_t'({`WORD_SIZE{1'b1}})) << {sb_offset, 3'b000};
    assign write_bits = line_t'(sb_head.value) << {sb_offset, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                tags[i]        <= '0;
                data[i]        <= '0;
                dirty[i]       <= 1'b0;
                pins[i]        <= '0;
                mrq_present[i] <= 1'b0;
                mrq_tag[i]     <= '0;
                mrq_pin[i]     <= '0;
            end
        end else begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                if (refill && res_set == set_t'(i)) begin
                    // New line inherits the pins collected while it was missing
                    tags[i]        <= res_tag;
                    data[i]        <= mem_res.data;
                    dirty[i]       <= 1'b0;
                    pins[i]        <= mrq_pin[i] + pin_t'(pin_on_mrq && req_set == set_t'(i));
                    mrq_present[i] <= 1'b0;
                    mrq_pin[i]     <= '0;
                end else begin
                    pins[i] <= pins[i] + pin_t'(pin_on_hit && req_set == set_t'(i))
                               - pin_t'(store_success && sb_set == set_t'(i));
                    if (pin_on_mrq && req_set == set_t'(i)) begin
                        mrq_pin[i] <= mrq_pin[i] + 1'b1;
                    end
                    if (mem_req.strobe && req_set == set_t'(i)) begin
                        mrq_present[i] <= 1'b1;
                        mrq_tag[i]     <= req_tag;
                    end
                    if (store_success && sb_set == set_t'(i)) begin
                        data[i]  <= (data[i] & ~write_mask) | (write_bits & write_mask);
                        dirty[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // Buffered stores keep their line resident until drained
    a_evict_unpinned: assert property (@(posedge clk) disable iff (rst)
        mem_wr.strobe |-> pins[res_set] == '0);

    // Every drained store lands on a line that it pinned earlier
    a_drain_pinned: assert property (@(posedge clk) disable iff (rst)
        store_success |-> pins[sb_set] != '0);

endmodule

// File: hdl/store_buffer.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module store_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  cache_types_pkg::sb_entry_t push_entry,
    input  logic                       pop,
    input  mem_types_pkg::word_t       load_addr,
    input  logic                       load_check,
    output cache_types_pkg::sb_entry_t head,
    output logic                       head_valid,
    output logic                       full,
    output logic                       conflict
);
    import mem_types_pkg::*;
    import cache_types_pkg::*;

    // Queue storage
    sb_entry_t slots [`SB_ENTRIES];
    logic [`SB_ENTRIES-1:0] slot_valid;

    // Pointers wrap naturally, depth is a power of two
    logic [$clog2(`SB_ENTRIES)-1:0] wr_ptr;
    logic [$clog2(`SB_ENTRIES)-1:0] rd_ptr;

    // Number of stores held
    pin_t count;

    // Per-slot line match against the load
    logic [`SB_ENTRIES-1:0] line_hit;

    assign head       = slots[rd_ptr];
    assign head_valid = count != '0;
    assign full       = count == pin_t'(`SB_ENTRIES);

    // Compare line addresses only, offset bits ignored
    always_comb begin
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            line_hit[i] = slot_valid[i]
                && slots[i].addr[`WORD_SIZE-1:`OFFSET_SIZE] == load_addr[`WORD_SIZE-1:`OFFSET_SIZE];
        end
    end

    assign conflict = load_check && |line_hit;

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot_valid <= '0;
        end else begin
            if (push) begin
                wr_ptr             <= wr_ptr + 1'b1;
                slot_valid[wr_ptr] <= 1'b1;
            end
            // Head leaves at the same edge as its cache write
            if (pop) begin
                rd_ptr             <= rd_ptr + 1'b1;
                slot_valid[rd_ptr] <= 1'b0;
            end
            count <= count + pin_t'(push) - pin_t'(pop);
        end
    end

    // Top level gates push on full, the cache gates pop on a valid head
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !((push && full) || (pop && !head_valid)));

endmodule

// File: hdl/line_memory.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module line_memory (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_types_pkg::mem_req_t req,
    input  cache_types_pkg::mem_wr_t  wr,
    output cache_types_pkg::mem_res_t res
);
    import mem_types_pkg::*;

    // Backing array of whole lines
    line_t lines [`MEM_LINES];

    // Refills in flight, stage 0 is the youngest
    logic [`MEM_LATENCY-1:0] pend_valid;
    word_t pend_addr [`MEM_LATENCY];

    // Line indices, upper address bits wrap
    logic [$clog2(`MEM_LINES)-1:0] rd_index;
    logic [$clog2(`MEM_LINES)-1:0] wr_index;

    assign rd_index = pend_addr[`MEM_LATENCY-1][`OFFSET_SIZE +: $clog2(`MEM_LINES)];
    assign wr_index = wr.addr[`OFFSET_SIZE +: $clog2(`MEM_LINES)];

    // Read on the way out, so earlier write-backs are visible
    assign res.strobe = pend_valid[`MEM_LATENCY-1];
    assign res.addr   = pend_addr[`MEM_LATENCY-1];
    assign res.data   = lines[rd_index];

    // Address pipeline
    always_ff @(posedge clk) begin
        pend_addr[0] <= req.addr;
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pend_addr[i] <= pend_addr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= '0;
            for (int i = 0; i < `MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else begin
            pend_valid <= {pend_valid[`MEM_LATENCY-2:0], req.strobe};
            // Victim line stored at the response edge
            if (wr.strobe) begin
                lines[wr_index] <= wr.data;
            end
        end
    end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_types_pkg::cpu_req_t req,
    output logic                      ready,
    output logic                      load_valid,
    output mem_types_pkg::word_t      load_data
);
    import mem_types_pkg::*;
    import cache_types_pkg::*;

    cpu_req_t  cache_req;
    sb_entry_t sb_push_entry;
    sb_entry_t sb_head;
    mem_req_t  mem_req;
    mem_res_t  mem_res;
    mem_wr_t   mem_wr;
    word_t     read_data;

    logic hit;
    logic store_stall;
    logic store_success;
    logic sb_full;
    logic sb_head_valid;
    logic sb_conflict;
    logic store_accept;
    logic load_accept;

    // Store is hidden from the cache while the buffer has no room
    always_comb begin
        cache_req       = req;
        cache_req.valid = req.valid && !(req.store && sb_full);
    end

    assign sb_push_entry = '{addr: req.addr, size: req.size, value: req.wdata};

    assign store_accept = req.valid && req.store && !sb_full && !store_stall;

    // Loads wait until no earlier store to the same line is buffered
    assign load_accept = req.valid && !req.store && hit && !sb_conflict;

    assign ready      = store_accept || load_accept;
    assign load_valid = load_accept;
    assign load_data  = read_data;

    dcache i_dcache (
        .clk          (clk),
        .rst          (rst),
        .req          (cache_req),
        .mem_res      (mem_res),
        .sb_head      (sb_head),
        .sb_drain     (sb_head_valid),
        .hit          (hit),
        .store_stall  (store_stall),
        .read_data    (read_data),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .store_success(store_success)
    );

    store_buffer i_store_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (store_accept),
        .push_entry(sb_push_entry),
        .pop       (store_success),
        .load_addr (req.addr),
        .load_check(req.valid && !req.store),
        .head      (sb_head),
        .head_valid(sb_head_valid),
        .full      (sb_full),
        .conflict  (sb_conflict)
    );

    line_memory i_line_memory (
        .clk(clk),
        .rst(rst),
        .req(mem_req),
        .wr (mem_wr),
        .res(mem_res)
    );

endmodule

// File: tests/mem_stage_tb.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module mem_stage_tb;
    import mem_types_pkg::*;
    import cache_types_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 8;
    // Worst case per access is a refill, a drain and a second refill
    localparam int CYCLES_PER_ENTRY = 3 * `MEM_LATENCY + `SB_ENTRIES + 10;
    // Outputs are read this long after the falling edge
    localparam int SAMPLE_DELAY     = 5;

    logic     clk;
    logic     rst;
    cpu_req_t req;
    logic     ready;
    logic     load_valid;
    word_t    load_data;

    // Trace columns with one queue element per access
    logic      trace_store  [$];
    acc_size_t trace_size   [$];
    word_t     trace_addr   [$];
    word_t     trace_wdata  [$];
    word_t     trace_expect [$];

    bit trace_loaded;
    int pass_count;
    int fail_count;

    mem_stage i_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ready     (ready),
        .load_valid(load_valid),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Comment and blank lines do not scan into five fields and are skipped
    task automatic load_trace();
        int fd;
        int fields;
        logic [8*128-1:0] line_buf;
        logic [31:0] f_op;
        logic [31:0] f_size;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_expect;
        fd = $fopen("tests/mem_stage_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/mem_stage_trace.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    fields = $sscanf(line_buf, "%h %h %h %h %h",
                                     f_op, f_size, f_addr, f_wdata, f_expect);
                    if (fields == 5) begin
                        trace_store.push_back(f_op[0]);
                        trace_size.push_back(acc_size_t'(f_size));
                        trace_addr.push_back(f_addr);
                        trace_wdata.push_back(f_wdata);
                        trace_expect.push_back(f_expect);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Line address of a byte address
    function automatic logic [`WORD_SIZE-`OFFSET_SIZE-1:0] line_of(input word_t addr);
        return addr[`WORD_SIZE-1:`OFFSET_SIZE];
    endfunction

    // True when an earlier access in the trace used the same line
    function automatic bit line_seen_before(input int idx);
        bit seen;
        seen = 1'b0;
        for (int j = 0; j < idx; j++) begin
            if (line_of(trace_addr[j]) == line_of(trace_addr[idx])) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    // One request held until ready and then checked against the trace
    task automatic run_access(input int idx);
        logic  got_valid;
        word_t got_data;
        word_t addr;
        int    waited;
        bit    ok;
        addr   = trace_addr[idx];
        waited = 0;
        @(negedge clk);
        req = '{valid: 1'b1, store: trace_store[idx], size: trace_size[idx],
                addr: addr, wdata: trace_wdata[idx]};
        #SAMPLE_DELAY;
        // Request stays on the bus under back-pressure
        while (!ready) begin
            @(negedge clk);
            #SAMPLE_DELAY;
            waited++;
        end
        got_valid = load_valid;
        got_data  = load_data;
        @(posedge clk);
        ok = 1'b1;
        if (trace_store[idx]) begin
            assert (!got_valid) else begin
                $display("[ERROR] load_valid expected %h got %h", 1'b0, got_valid);
                ok = 1'b0;
            end
        end else begin
            assert (got_valid) else begin
                $display("[ERROR] load_valid expected %h got %h", 1'b1, got_valid);
                ok = 1'b0;
            end
            assert (got_data == trace_expect[idx]) else begin
                $display("[ERROR] load_data expected %h got %h", trace_expect[idx], got_data);
                ok = 1'b0;
            end
            // The previous load brought this line in, so it hits at once
            if (idx > 0 && !trace_store[idx-1]
                    && line_of(trace_addr[idx-1]) == line_of(addr)) begin
                assert (waited == 0) else begin
                    $display("Load at %h should hit but waited %0d cycles for ready",
                             addr, waited);
                    ok = 1'b0;
                end
            end
            // First use of a line with a nonzero tag waits for a whole refill
            if (!line_seen_before(idx) && addr[`WORD_SIZE-1 -: `TAG_SIZE] != '0) begin
                assert (waited >= `MEM_LATENCY + 1) else begin
                    $display("Load at %h missed but ready rose after %0d cycles",
                             addr, waited);
                    ok = 1'b0;
                end
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("access %0d %s at %h %s", idx, trace_store[idx] ? "store" : "load",
                 trace_addr[idx], ok ? "ok" : "FAILED");
    endtask

    // Watchdog scaled to the trace length
    initial begin
        longint watchdog_ns;
        wait (trace_loaded);
        watchdog_ns = longint'(RESET_CYCLES + trace_addr.size() * CYCLES_PER_ENTRY)
                      * CLK_PERIOD;
        #(watchdog_ns);
        $display("Timeout, the DUT stopped answering before the trace ended");
        $display("test failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        req          = '0;
        pass_count   = 0;
        fail_count   = 0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < trace_addr.size(); i++) begin
            run_access(i);
        end
        @(negedge clk);
        req = '0;
        $display("%0d accesses ok, %0d accesses failed", pass_count, fail_count);
        if (fail_count == 0 && trace_addr.size() != 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hdl/mem_types_pkg.sv
hdl/cache_types_pkg.sv
hdl/dcache.sv
hdl/store_buffer.sv
hdl/line_memory.sv
hdl/mem_stage.sv
tests/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the mem_stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module mem_stage_tb -Mdir obj_dir -o mem_stage_sim > build.log 2>&1 &&
./obj_dir/mem_stage_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && echo "Simulation ok" ||
    { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

// File: tests/mem_stage_trace.txt
# op (0 load, 1 store)  size (0 byte, 2 word)  address  store data  expected load data
# all values hex, expected data is ignored for stores
0 2 00000100 00000000 00000000
0 0 00000104 00000000 00000000
1 2 00000108 12345678 00000000
0 2 00000108 00000000 12345678
1 0 00000109 0000009a 00000000
0 0 00000109 00000000 ffffff9a
0 2 00000108 00000000 12349a78
1 2 00000214 cafef00d 00000000
0 2 00000214 00000000 cafef00d
0 2 00000180 00000000 00000000
0 2 00000108 00000000 12349a78
1 2 0000010c 0badbeef 00000000
0 2 00000184 00000000 00000000
0 2 0000010c 00000000 0badbeef
0 0 0000010f 00000000 0000000b
1 2 00000224 0000a5a5 00000000
1 2 00000238 80000001 00000000
1 2 0000024c 7654321f 00000000
0 2 00000224 00000000 0000a5a5
0 2 00000238 00000000 80000001
0 0 0000024f 00000000 00000076
0 2 00000234 00000000 00000000
